// ==== project.f ====
verilog/uart_pkg.sv
verilog/uart_frame_tx.sv
verilog/uart_frame_rx.sv
verilog/uart_cmd_seq.sv
verilog/uart_cmd_bridge.sv
verif/uart_cmd_bridge_chk.sv
verif/tb_uart_cmd_bridge.sv

// ==== run.sh ====
#!/bin/sh

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -rf obj_dir

verilator --binary --timing --assert -Wno-fatal -f project.f \
  --top-module tb_uart_cmd_bridge -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "No errors" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1

// ==== verif/tb_uart_cmd_bridge.sv ====
`timescale 1ns/1ps

module tb_uart_cmd_bridge;
  import uart_pkg::*;

  localparam int NUM_CMDS   = 200;
  localparam int FRAME_CLKS = 11 * BIT_CLKS;
  localparam int GAP_CLKS   = GAP_BITS * BIT_CLKS;
  // Worst case per command is a request frame, a full response timeout and idle time
  localparam int TIMEOUT_CYCLES = NUM_CMDS * (FRAME_CLKS + RSP_TIMEOUT_BITS * BIT_CLKS + 400);

  localparam logic [1:0] KIND_RD_HI = 2'd0;
  localparam logic [1:0] KIND_WR_HI = 2'd1;
  localparam logic [1:0] KIND_WR_LO = 2'd2;

  logic              clk;
  logic              rst_n;
  logic [CMD_W-1:0]  cmd_in;
  logic              cmd_vld;
  logic              cmd_rdy;
  logic              rx;
  logic              tx;
  logic [DATA_W-1:0] read_data;
  logic              read_rdy;
  logic              read_err;

  integer            seed;
  int                cycle;
  logic [DATA_W-1:0] mem [0:(1<<ADDR_W)-1]; // Remote register file
  logic [DATA_W-1:0] exp_byte_q [$];
  logic [1:0]        exp_kind_q [$];
  logic [DATA_W:0]   exp_rsp_q [$];  // {read_err, read_data}
  logic [ADDR_W-1:0] req_addr_q [$];

  uart_cmd_bridge u_uart_cmd_bridge (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .rx        (rx),
    .tx        (tx),
    .read_data (read_data),
    .read_rdy  (read_rdy),
    .read_err  (read_err)
  );

  always #10 clk = ~clk;

  task automatic abort_run();
    $display("Errors found");
    $fatal(1, "Run stopped at cycle %0d", cycle);
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected)
    begin
      $display("MISMATCH %s expected 0x%0h actual 0x%0h", name, expected, actual);
      abort_run();
    end
  endtask

  function automatic int rand_below(input int n);
    logic [31:0] rnd;
    rnd = $random(seed);
    return int'(rnd % 32'(n));
  endfunction

  task automatic drive_random_command();
    logic [31:0] rnd;
    rnd = $random(seed);
    cmd_in  <= rnd[CMD_W-1:0];
    cmd_vld <= 1'b1;
  endtask

  // Frames the accepted command must put on tx
  task automatic record_command(input logic [CMD_W-1:0] cmd);
    exp_byte_q.push_back(cmd[CMD_W-1:DATA_W]);
    if (cmd[CMD_W-1])
    begin
      exp_kind_q.push_back(KIND_WR_HI);
      exp_byte_q.push_back(cmd[DATA_W-1:0]);
      exp_kind_q.push_back(KIND_WR_LO);
    end
    else
      exp_kind_q.push_back(KIND_RD_HI);
  endtask

  task automatic send_frame(input logic [DATA_W-1:0] data, input logic par, input logic stop);
    logic [10:0] bits;
    bits = {stop, par, data, 1'b0};
    for (int i = 0; i < 11; i++)
    begin
      rx <= bits[i];
      repeat (BIT_CLKS) @(posedge clk);
    end
    rx <= 1'b1;
  endtask

  always @(posedge clk)
  begin
    cycle <= cycle + 1;
    if (cycle >= TIMEOUT_CYCLES)
    begin
      $display("Timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      abort_run();
    end
  end

  initial
  begin : stimulus
    int gap;
    int accepted;
    int refused;
    seed    = 32'hac36_f0e9;
    cycle   = 0;
    clk     = 1'b0;
    rst_n   = 1'b0;
    cmd_in  = '0;
    cmd_vld = 1'b0;
    rx      = 1'b1;
    for (int a = 0; a < (1 << ADDR_W); a++)
      mem[a] = 8'(a * 37 + 11); // Differs at every address
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    repeat (2)
    begin
      @(posedge clk);
      check_value("reset_tx", 1, tx);
      check_value("reset_cmd_rdy", 1, cmd_rdy);
      check_value("reset_read_rdy", 0, read_rdy);
      check_value("reset_read_err", 0, read_err);
      check_value("reset_read_data", 0, read_data);
    end
    gap      = 0;
    accepted = 0;
    refused  = 0;
    while (accepted < NUM_CMDS)
    begin
      @(posedge clk);
      if (cmd_vld && cmd_rdy)
      begin
        record_command(cmd_in);
        accepted = accepted + 1;
        cmd_vld <= 1'b0;
        gap = rand_below(8);
      end
      else if (cmd_rdy)
      begin
        if (gap > 0)
          gap = gap - 1;
        else
          drive_random_command();
      end
      else if (cmd_vld)
      begin
        refused = refused + 1; // Offered while busy
        cmd_vld <= 1'b0;
      end
      else if (rand_below(16) == 0)
        drive_random_command();
    end
    do
      @(posedge clk);
    while (!cmd_rdy);
    repeat (2 * FRAME_CLKS) @(posedge clk); // Room for stray frames
    if ((exp_byte_q.size() == 0) && (exp_rsp_q.size() == 0) && (req_addr_q.size() == 0))
    begin
      $display("%0d commands accepted, %0d busy offers refused", accepted, refused);
      $display("No errors");
      $finish;
    end
    else
    begin
      $display("Run ended with frames or read results still outstanding");
      abort_run();
    end
  end

  initial
  begin : tx_monitor
    logic [DATA_W-1:0] data;
    logic              par;
    logic              stop;
    logic [DATA_W-1:0] exp_byte;
    logic [1:0]        kind;
    logic [ADDR_W-1:0] wr_addr;
    int                start_cycle;
    int                prev_start;
    prev_start = 0;
    wr_addr    = '0;
    forever
    begin
      @(posedge clk);
      if (rst_n && (tx == 1'b0))
      begin
        start_cycle = cycle;
        if (exp_byte_q.size() == 0)
        begin
          $display("Frame on tx at cycle %0d with no accepted command behind it", cycle);
          abort_run();
        end
        else
        begin
          exp_byte = exp_byte_q.pop_front();
          kind     = exp_kind_q.pop_front();
          repeat (BIT_CLKS / 2 - 1) @(posedge clk); // Middle of the start bit
          check_value("tx_start_bit", 0, tx);
          for (int i = 0; i < DATA_W; i++)
          begin
            repeat (BIT_CLKS) @(posedge clk);
            data[i] = tx;
            check_value("cmd_rdy_during_frame", 0, cmd_rdy);
          end
          repeat (BIT_CLKS) @(posedge clk);
          par = tx;
          repeat (BIT_CLKS) @(posedge clk);
          stop = tx;
          check_value("tx_odd_parity", 1, ^{data, par});
          check_value("tx_stop_bit", 1, stop);
          check_value("tx_frame_byte", exp_byte, data);
          if (kind == KIND_WR_HI)
            wr_addr = data[ADDR_W-1:0];
          else if (kind == KIND_WR_LO)
          begin
            if (start_cycle - prev_start < FRAME_CLKS + GAP_CLKS)
            begin
              $display("Write data frame started only %0d clocks after the address frame",
                       start_cycle - prev_start);
              abort_run();
            end
            mem[wr_addr] = data;
          end
          else
            req_addr_q.push_back(data[ADDR_W-1:0]); // Read request for the responder
          prev_start = start_cycle;
        end
      end
    end
  end

  // Remote device answers each read cleanly, corrupted or not at all
  initial
  begin : remote_responder
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
    logic              par;
    logic              stop;
    int                pick;
    int                delay_bits;
    forever
    begin
      @(posedge clk);
      if (req_addr_q.size() != 0)
      begin
        addr = req_addr_q.pop_front();
        data = mem[addr];
        par  = ~(^data); // Odd count over data plus parity
        stop = 1'b1;
        pick = rand_below(3);
        if (pick == 2)
          exp_rsp_q.push_back({1'b1, 8'h00}); // Silence ends in the timeout
        else
        begin
          if (pick == 1)
          begin
            if (rand_below(2) == 0)
              par = ~par;
            else
              stop = 1'b0;
          end
          exp_rsp_q.push_back({(pick == 1), data});
          delay_bits = 1 + rand_below(20);
          repeat (BIT_CLKS / 2 + delay_bits * BIT_CLKS) @(posedge clk);
          send_frame(data, par, stop);
        end
      end
    end
  end

  always @(posedge clk)
  begin : read_check
    logic [DATA_W:0] exp_rsp;
    if (rst_n && read_rdy)
    begin
      if (exp_rsp_q.size() == 0)
      begin
        $display("read_rdy pulsed at cycle %0d with no read outstanding", cycle);
        abort_run();
      end
      else
      begin
        exp_rsp = exp_rsp_q.pop_front();
        check_value("read_data", exp_rsp[DATA_W-1:0], read_data);
        check_value("read_err", exp_rsp[DATA_W], read_err);
      end
    end
  end

endmodule

// ==== verif/uart_cmd_bridge_chk.sv ====
`timescale 1ns/1ps

module uart_cmd_bridge_chk (
  input logic clk,
  input logic rst_n,
  input logic cmd_rdy,
  input logic tx,
  input logic read_rdy,
  input logic read_err
);

  a_read_rdy_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    read_rdy |=> !read_rdy)
    else $error("read_rdy stayed high for two cycles");

  a_tx_idle_when_rdy: assert property (@(posedge clk) disable iff (!rst_n)
    cmd_rdy |-> tx)
    else $error("tx left idle while cmd_rdy is high");

  a_err_only_with_rdy: assert property (@(posedge clk) disable iff (!rst_n)
    !read_rdy |-> !read_err)
    else $error("read_err high without read_rdy");

  // First clock out of reset
  a_reset_exit: assert property (@(posedge clk) $rose(rst_n) |-> (tx && cmd_rdy))
    else $error("tx or cmd_rdy low on the first cycle after reset");

endmodule

bind uart_cmd_bridge uart_cmd_bridge_chk u_uart_cmd_bridge_chk (
  .clk      (clk),
  .rst_n    (rst_n),
  .cmd_rdy  (cmd_rdy),
  .tx       (tx),
  .read_rdy (read_rdy),
  .read_err (read_err)
);

// ==== verilog/uart_cmd_bridge.sv ====
`timescale 1ns/1ps

module uart_cmd_bridge (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic [uart_pkg::CMD_W-1:0]  cmd_in,
  input  logic                        cmd_vld,
  output logic                        cmd_rdy,
  input  logic                        rx,
  output logic                        tx,
  output logic [uart_pkg::DATA_W-1:0] read_data,
  output logic                        read_rdy,
  output logic                        read_err
);
  import uart_pkg::*;

  logic              tx_start;
  logic [DATA_W-1:0] tx_byte;
  logic              tx_busy;
  logic [DATA_W-1:0] rx_byte;
  logic              rx_vld;
  logic              rx_frame_err;
  logic              rx_start_seen;

  uart_cmd_seq u_uart_cmd_seq (
    .clk           (clk),
    .rst_n         (rst_n),
    .cmd_in        (cmd_in),
    .cmd_vld       (cmd_vld),
    .cmd_rdy       (cmd_rdy),
    .tx_start      (tx_start),
    .tx_byte       (tx_byte),
    .tx_busy       (tx_busy),
    .rx_byte       (rx_byte),
    .rx_vld        (rx_vld),
    .rx_frame_err  (rx_frame_err),
    .rx_start_seen (rx_start_seen),
    .read_data     (read_data),
    .read_rdy      (read_rdy),
    .read_err      (read_err)
  );

  uart_frame_tx u_uart_frame_tx (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_start (tx_start),
    .tx_byte  (tx_byte),
    .tx_busy  (tx_busy),
    .tx       (tx)
  );

  uart_frame_rx u_uart_frame_rx (
    .clk           (clk),
    .rst_n         (rst_n),
    .rx            (rx),
    .rx_byte       (rx_byte),
    .rx_vld        (rx_vld),
    .rx_frame_err  (rx_frame_err),
    .rx_start_seen (rx_start_seen)
  );

endmodule

// ==== verilog/uart_cmd_seq.sv ====
`timescale 1ns/1ps

module uart_cmd_seq (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic [uart_pkg::CMD_W-1:0]  cmd_in,
  input  logic                        cmd_vld,
  output logic                        cmd_rdy,
  output logic                        tx_start,
  output logic [uart_pkg::DATA_W-1:0] tx_byte,
  input  logic                        tx_busy,
  input  logic [uart_pkg::DATA_W-1:0] rx_byte,
  input  logic                        rx_vld,
  input  logic                        rx_frame_err,
  input  logic                        rx_start_seen,
  output logic [uart_pkg::DATA_W-1:0] read_data,
  output logic                        read_rdy,
  output logic                        read_err
);
  import uart_pkg::*;

  seq_state_e           state;
  logic [CMD_W-1:0]     cmd_q;
  op_e                  op;
  logic [ADDR_W-1:0]    addr;
  logic                 frame_done;
  logic                 timing;
  logic                 bit_end;
  logic [BIT_CNT_W-1:0] clk_cnt;
  logic [BITS_W-1:0]    bit_cnt;

  assign op      = op_e'(cmd_q[CMD_W-1]);
  assign addr    = cmd_q[CMD_W-2 -: ADDR_W];
  assign cmd_rdy = (state == S_IDLE);

  // High byte is flag plus address, low byte is write data
  assign tx_byte = (state == S_SEND_LO) ? cmd_q[DATA_W-1:0] : {op, addr};

  // Start pulse has gone out and the transmitter has finished
  assign frame_done = !tx_start && !tx_busy;

  assign timing  = (state == S_GAP) || (state == S_WAIT_RSP);
  assign bit_end = (clk_cnt == BIT_LAST);

  always_ff @(posedge clk)
  begin
    if (cmd_vld && cmd_rdy)
      cmd_q <= cmd_in;
  end

  // Shared bit-time counter for the write gap and the response timeout
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      clk_cnt <= '0;
      bit_cnt <= '0;
    end
    else if (timing)
    begin
      if (bit_end)
      begin
        clk_cnt <= '0;
        bit_cnt <= bit_cnt + 1'b1;
      end
      else
      begin
        clk_cnt <= clk_cnt + 1'b1;
      end
    end
    else
    begin
      clk_cnt <= '0;
      bit_cnt <= '0;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state     <= S_IDLE;
      tx_start  <= 1'b0;
      read_data <= '0;
      read_rdy  <= 1'b0;
      read_err  <= 1'b0;
    end
    else
    begin
      tx_start <= 1'b0;
      read_rdy <= 1'b0;
      read_err <= 1'b0;
      case (state)
        S_IDLE:
        begin
          if (cmd_vld)
          begin
            state    <= S_SEND_HI;
            tx_start <= 1'b1;
          end
        end
        S_SEND_HI:
        begin
          if (frame_done)
            state <= (op == OP_WRITE) ? S_GAP : S_WAIT_RSP;
        end
        S_GAP:
        begin
          if (bit_end && (bit_cnt == GAP_LAST))
          begin
            state    <= S_SEND_LO;
            tx_start <= 1'b1;
          end
        end
        S_SEND_LO:
        begin
          if (frame_done)
            state <= S_DONE;
        end
        S_WAIT_RSP:
        begin
          if (rx_start_seen)
            state <= S_RECV;
          else if (bit_end && (bit_cnt == TMO_LAST))
          begin
            state     <= S_DONE; // No answer from the remote side
            read_data <= '0;
            read_rdy  <= 1'b1;
            read_err  <= 1'b1;
          end
        end
        S_RECV:
        begin
          if (rx_vld)
          begin
            state     <= S_DONE;
            read_data <= rx_byte;
            read_rdy  <= 1'b1;
            read_err  <= rx_frame_err;
          end
        end
        S_DONE:
        begin
          state <= S_IDLE;
        end
        default:
        begin
          state <= S_IDLE;
        end
      endcase
    end
  end

endmodule

// ==== verilog/uart_frame_rx.sv ====
`timescale 1ns/1ps

module uart_frame_rx (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        rx,
  output logic [uart_pkg::DATA_W-1:0] rx_byte,
  output logic                        rx_vld,
  output logic                        rx_frame_err,
  output logic                        rx_start_seen
);
  import uart_pkg::*;

  logic                 rx_meta;
  logic                 rx_sync;
  logic                 rx_last;
  logic                 fall;
  logic                 active;
  logic [BIT_CNT_W-1:0] clk_cnt;
  logic [IDX_W-1:0]     bit_idx;
  logic [DATA_W-1:0]    shift_q;
  logic                 par_q;
  logic                 sample;

  assign fall = rx_last & ~rx_sync;

  // Start bit is checked after half a bit, the rest at full bit steps
  assign sample = active &&
                  (((bit_idx == '0) && (clk_cnt == HALF_LAST)) ||
                   ((bit_idx != '0) && (clk_cnt == BIT_LAST)));

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_meta       <= 1'b1;
      rx_sync       <= 1'b1;
      rx_last       <= 1'b1;
      active        <= 1'b0;
      clk_cnt       <= '0;
      bit_idx       <= '0;
      rx_vld        <= 1'b0;
      rx_start_seen <= 1'b0;
    end
    else
    begin
      rx_meta       <= rx;
      rx_sync       <= rx_meta;
      rx_last       <= rx_sync;
      rx_vld        <= 1'b0;
      rx_start_seen <= 1'b0;
      if (!active)
      begin
        clk_cnt <= '0;
        bit_idx <= '0;
        if (fall)
          active <= 1'b1;
      end
      else if (sample)
      begin
        clk_cnt <= '0;
        if (bit_idx == '0)
        begin
          if (rx_sync)
            active <= 1'b0; // Glitch, back to hunting
          else
          begin
            rx_start_seen <= 1'b1;
            bit_idx       <= bit_idx + 1'b1;
          end
        end
        else if (bit_idx == IDX_STOP)
        begin
          active <= 1'b0;
          rx_vld <= 1'b1;
        end
        else
        begin
          bit_idx <= bit_idx + 1'b1;
        end
      end
      else
      begin
        clk_cnt <= clk_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (sample && (bit_idx != '0))
    begin
      if (bit_idx <= IDX_DATA_LAST)
        shift_q <= {rx_sync, shift_q[DATA_W-1:1]}; // LSB arrives first
      else if (bit_idx == IDX_PAR)
        par_q <= rx_sync;
      else
      begin
        rx_byte      <= shift_q;
        rx_frame_err <= ~(^{shift_q, par_q}) | ~rx_sync; // Even count or bad stop
      end
    end
  end

endmodule

// ==== verilog/uart_frame_tx.sv ====
`timescale 1ns/1ps

module uart_frame_tx (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        tx_start,
  input  logic [uart_pkg::DATA_W-1:0] tx_byte,
  output logic                        tx_busy,
  output logic                        tx
);
  import uart_pkg::*;

  logic                 busy;
  logic [BIT_CNT_W-1:0] clk_cnt;
  logic [IDX_W-1:0]     bit_idx;
  logic [DATA_W-1:0]    byte_q;
  logic                 parity;
  logic                 next_bit;

  assign tx_busy = busy;
  assign parity  = ~^byte_q; // Odd parity over the data bits

  // Value of the bit that follows bit_idx
  always_comb
  begin
    if (bit_idx < IDX_DATA_LAST)
      next_bit = byte_q[bit_idx[$clog2(DATA_W)-1:0]]; // LSB first
    else if (bit_idx == IDX_DATA_LAST)
      next_bit = parity;
    else
      next_bit = 1'b1; // Stop
  end

  always_ff @(posedge clk)
  begin
    if (tx_start)
      byte_q <= tx_byte;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      busy    <= 1'b0;
      clk_cnt <= '0;
      bit_idx <= '0;
      tx      <= 1'b1;
    end
    else if (tx_start)
    begin
      busy    <= 1'b1;
      clk_cnt <= '0;
      bit_idx <= '0;
      tx      <= 1'b0; // Start bit
    end
    else if (busy)
    begin
      if (clk_cnt == BIT_LAST)
      begin
        clk_cnt <= '0;
        if (bit_idx == IDX_STOP)
        begin
          busy <= 1'b0;
          tx   <= 1'b1;
        end
        else
        begin
          bit_idx <= bit_idx + 1'b1;
          tx      <= next_bit;
        end
      end
      else
      begin
        clk_cnt <= clk_cnt + 1'b1;
      end
    end
  end

endmodule

// ==== verilog/uart_pkg.sv ====
package uart_pkg;

  // Command and payload widths
  localparam int CMD_W  = 16;
  localparam int DATA_W = 8;
  localparam int ADDR_W = 7;

  // Serial timing
  localparam int BIT_CLKS         = 16;
  localparam int GAP_BITS         = 2;
  localparam int RSP_TIMEOUT_BITS = 64;

  // Clock counter inside one bit time
  localparam int                   BIT_CNT_W = $clog2(BIT_CLKS);
  localparam logic [BIT_CNT_W-1:0] BIT_LAST  = BIT_CNT_W'(BIT_CLKS - 1);
  localparam logic [BIT_CNT_W-1:0] HALF_LAST = BIT_CNT_W'(BIT_CLKS / 2 - 1);

  // Bit index within a frame: 0 start, 1..8 data, 9 parity, 10 stop
  localparam int               IDX_W         = 4;
  localparam logic [IDX_W-1:0] IDX_DATA_LAST = IDX_W'(DATA_W);
  localparam logic [IDX_W-1:0] IDX_PAR       = IDX_W'(DATA_W + 1);
  localparam logic [IDX_W-1:0] IDX_STOP      = IDX_W'(DATA_W + 2);

  // Bit-time counter in the sequencer, sized for the response timeout
  localparam int                BITS_W   = $clog2(RSP_TIMEOUT_BITS);
  localparam logic [BITS_W-1:0] GAP_LAST = BITS_W'(GAP_BITS - 1);
  localparam logic [BITS_W-1:0] TMO_LAST = BITS_W'(RSP_TIMEOUT_BITS - 1);

  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } op_e;

  typedef enum logic [2:0] {
    S_IDLE,
    S_SEND_HI,
    S_GAP,
    S_SEND_LO,
    S_WAIT_RSP,
    S_RECV,
    S_DONE
  } seq_state_e;

endpackage
